// File: hdl/exec_pkg.sv
package exec_pkg;

    // opcodes follow the decode stage encoding
    typedef enum logic [7:0] {
        OP_NOP   = 8'b0000_0000,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_MFHI  = 8'b0001_0000,
        OP_MTHI  = 8'b0001_0001,
        OP_MFLO  = 8'b0001_0010,
        OP_MTLO  = 8'b0001_0011,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_DIV   = 8'b0001_1010,
        OP_DIVU  = 8'b0001_1011,
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_AND   = 8'b0010_0100,
        OP_OR    = 8'b0010_0101,
        OP_XOR   = 8'b0010_0110,
        OP_NOR   = 8'b0010_0111,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_TGE   = 8'b0011_0000,
        OP_TGEU  = 8'b0011_0001,
        OP_TLT   = 8'b0011_0010,
        OP_TLTU  = 8'b0011_0011,
        OP_TEQ   = 8'b0011_0100,
        OP_TNE   = 8'b0011_0110,
        OP_SLL   = 8'b0111_1100,
        OP_MADD  = 8'b1010_0110,
        OP_MADDU = 8'b1010_1000,
        OP_MUL   = 8'b1010_1001,
        OP_MSUB  = 8'b1010_1010,
        OP_MSUBU = 8'b1010_1011
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101
    } alusel_e;

    typedef struct packed {
        aluop_e      op;
        alusel_e     sel;
        logic [31:0] reg1;
        logic [31:0] reg2;
        logic [4:0]  wd;   // destination register
        logic        wreg;
    } issue_t;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } hilo_pair_t;

    // same 64 bits seen as the register pair or as one accumulator
    typedef union packed {
        hilo_pair_t  half;
        logic [63:0] acc;
    } hilo_u;

    typedef struct packed {
        logic [4:0]  wd;
        logic        wreg;
        logic [31:0] wdata;
        logic        whilo;
        hilo_u       hilo;
        logic        ov;
        logic        trap;
    } result_t;

    typedef struct packed {
        logic        start;  // level, held through the divide
        logic        sign;
        logic [31:0] op1;
        logic [31:0] op2;
    } div_req_t;

    typedef struct packed {
        logic  ready;     // one cycle pulse
        hilo_u quot_rem;  // remainder in hi, quotient in lo
    } div_rsp_t;

endpackage

// File: hdl/alu_core.sv
`timescale 1ns/100ps

module alu_core
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  issue_t   issue_i,
    input  logic     issue_valid_i,
    input  logic     fwd_whilo_i,
    input  hilo_u    fwd_hilo_i,
    input  hilo_u    hilo_i,
    input  div_rsp_t div_rsp_i,
    output div_req_t div_req_o,
    output result_t  result_o,
    output logic     stall_o
);
    aluop_e             op;
    logic [31:0]        reg1;
    logic [31:0]        reg2;
    logic [31:0]        reg2_mux;
    logic [31:0]        sum;
    logic               ov_sum;
    logic               sub_op;
    logic               signed_cmp;
    logic               lt;
    logic [31:0]        logic_res;
    logic [31:0]        shift_res;
    logic [31:0]        move_res;
    logic [31:0]        arith_res;
    logic               mul_signed;
    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [65:0] mul_full;
    hilo_u              product;
    hilo_u              hilo_cur;
    hilo_u              madd_sum;
    logic               madd_op;
    logic               msub_op;
    logic               div_op;
    logic               step_q;   // madd/msub step count
    logic [63:0]        prod_q;
    logic               stall_madd;
    logic               stall_div;
    logic               overflow;
    logic               trap;

    assign op   = issue_i.op;
    assign reg1 = issue_i.reg1;
    assign reg2 = issue_i.reg2;

    assign sub_op = (op == OP_SUB) || (op == OP_SUBU) || (op == OP_SLT) ||
                    (op == OP_TLT) || (op == OP_TGE);
    assign signed_cmp = (op == OP_SLT) || (op == OP_TLT) || (op == OP_TGE);

    assign reg2_mux = sub_op ? (~reg2 + 32'd1) : reg2;
    assign sum      = reg1 + reg2_mux;
    assign ov_sum   = (!reg1[31] && !reg2_mux[31] && sum[31]) ||
                      (reg1[31] && reg2_mux[31] && !sum[31]);

    // signed order from the difference, unsigned by plain compare
    assign lt = signed_cmp ? ((reg1[31] && !reg2[31]) ||
                              (reg1[31] == reg2[31] && sum[31]))
                           : (reg1 < reg2);

    // most recent hi/lo, the pending write wins
    assign hilo_cur = fwd_whilo_i ? fwd_hilo_i : hilo_i;

    assign mul_signed = (op == OP_MUL) || (op == OP_MULT) ||
                        (op == OP_MADD) || (op == OP_MSUB);
    assign mul_a       = {mul_signed & reg1[31], reg1};
    assign mul_b       = {mul_signed & reg2[31], reg2};
    assign mul_full    = mul_a * mul_b;
    assign product.acc = mul_full[63:0];

    assign madd_op = (op == OP_MADD) || (op == OP_MADDU);
    assign msub_op = (op == OP_MSUB) || (op == OP_MSUBU);
    assign div_op  = (op == OP_DIV) || (op == OP_DIVU);

    assign madd_sum.acc = prod_q + hilo_cur.acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            step_q <= 1'b0;
        end else if (issue_valid_i && (madd_op || msub_op)) begin
            step_q <= ~step_q;
        end else begin
            step_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i && (madd_op || msub_op) && !step_q) begin
            prod_q <= msub_op ? (~product.acc + 64'd1) : product.acc;
        end
    end

    assign stall_madd = issue_valid_i && (madd_op || msub_op) && !step_q;
    assign stall_div  = issue_valid_i && div_op && !div_rsp_i.ready;
    assign stall_o    = stall_madd || stall_div;

    assign div_req_o.start = stall_div;  // dropped on the ready pulse
    assign div_req_o.sign  = (op == OP_DIV);
    assign div_req_o.op1   = reg1;
    assign div_req_o.op2   = reg2;

    always_comb begin
        case (op)
            OP_OR:   logic_res = reg1 | reg2;
            OP_AND:  logic_res = reg1 & reg2;
            OP_NOR:  logic_res = ~(reg1 | reg2);
            OP_XOR:  logic_res = reg1 ^ reg2;
            default: logic_res = 32'd0;
        endcase
    end

    always_comb begin
        case (op)
            OP_SLL:  shift_res = reg2 << reg1[4:0];
            OP_SRL:  shift_res = reg2 >> reg1[4:0];
            OP_SRA:  shift_res = $signed(reg2) >>> reg1[4:0];
            default: shift_res = 32'd0;
        endcase
    end

    always_comb begin
        case (op)
            OP_MFHI: move_res = hilo_cur.half.hi;
            OP_MFLO: move_res = hilo_cur.half.lo;
            default: move_res = 32'd0;
        endcase
    end

    always_comb begin
        case (op)
            OP_SLT, OP_SLTU: arith_res = {31'd0, lt};
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: arith_res = sum;
            default: arith_res = 32'd0;
        endcase
    end

    always_comb begin
        case (op)
            OP_TEQ:          trap = (reg1 == reg2);
            OP_TNE:          trap = (reg1 != reg2);
            OP_TGE, OP_TGEU: trap = !lt;
            OP_TLT, OP_TLTU: trap = lt;
            default:         trap = 1'b0;
        endcase
    end

    assign overflow = ((op == OP_ADD) || (op == OP_SUB)) && ov_sum;

    always_comb begin
        result_o.wd    = issue_i.wd;
        result_o.wreg  = issue_i.wreg && !overflow;  // no write on overflow
        result_o.ov    = overflow;
        result_o.trap  = trap;
        result_o.whilo = 1'b0;
        result_o.hilo  = '0;

        case (issue_i.sel)
            SEL_LOGIC: result_o.wdata = logic_res;
            SEL_SHIFT: result_o.wdata = shift_res;
            SEL_MOVE:  result_o.wdata = move_res;
            SEL_ARITH: result_o.wdata = arith_res;
            SEL_MUL:   result_o.wdata = product.half.lo;
            default:   result_o.wdata = 32'd0;
        endcase

        case (op)
            OP_MTHI: begin
                result_o.whilo        = 1'b1;
                result_o.hilo.half.hi = reg1;
                result_o.hilo.half.lo = hilo_cur.half.lo;
            end
            OP_MTLO: begin
                result_o.whilo        = 1'b1;
                result_o.hilo.half.hi = hilo_cur.half.hi;
                result_o.hilo.half.lo = reg1;
            end
            OP_MUL, OP_MULT, OP_MULTU: begin
                result_o.whilo = 1'b1;
                result_o.hilo  = product;
            end
            OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU: begin
                result_o.whilo = 1'b1;
                result_o.hilo  = madd_sum;  // only captured on the second step
            end
            OP_DIV, OP_DIVU: begin
                result_o.whilo = 1'b1;
                result_o.hilo  = div_rsp_i.quot_rem;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: hdl/div_unit.sv
`timescale 1ns/100ps

module div_unit
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  div_req_t req_i,
    output div_rsp_t rsp_o
);
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BY_ZERO,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e  state_q;
    logic [4:0]  cnt_q;
    logic        ready_q;
    logic [31:0] dvs_q;
    logic [31:0] rem_q;
    logic [31:0] quo_q;
    logic        neg_quo_q;
    logic        neg_rem_q;
    hilo_u       res_q;
    logic [31:0] dvd_mag;
    logic [31:0] dvs_mag;
    logic [32:0] trial;
    logic [32:0] diff;

    assign dvd_mag = (req_i.sign && req_i.op1[31]) ? (~req_i.op1 + 32'd1) : req_i.op1;
    assign dvs_mag = (req_i.sign && req_i.op2[31]) ? (~req_i.op2 + 32'd1) : req_i.op2;

    // shift in the next dividend bit and try the subtract
    assign trial = {rem_q, quo_q[31]};
    assign diff  = trial - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DIV_IDLE;
            cnt_q   <= 5'd0;
            ready_q <= 1'b0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    ready_q <= 1'b0;
                    cnt_q   <= 5'd0;
                    if (req_i.start) begin
                        state_q <= (req_i.op2 == 32'd0) ? DIV_BY_ZERO : DIV_RUN;
                    end
                end
                DIV_BY_ZERO: begin
                    if (!req_i.start) begin
                        state_q <= DIV_IDLE;
                    end else begin
                        ready_q <= 1'b1;
                        state_q <= DIV_DONE;
                    end
                end
                DIV_RUN: begin
                    if (!req_i.start) begin
                        state_q <= DIV_IDLE;  // cancelled
                    end else begin
                        cnt_q <= cnt_q + 5'd1;
                        if (cnt_q == 5'd31) begin
                            state_q <= DIV_DONE;
                        end
                    end
                end
                DIV_DONE: begin
                    ready_q <= req_i.start && !ready_q;
                    if (!req_i.start) begin
                        state_q <= DIV_IDLE;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            DIV_IDLE: begin
                rem_q     <= 32'd0;
                quo_q     <= dvd_mag;
                dvs_q     <= dvs_mag;
                neg_quo_q <= req_i.sign && (req_i.op1[31] ^ req_i.op2[31]);
                neg_rem_q <= req_i.sign && req_i.op1[31];  // remainder follows dividend
            end
            DIV_BY_ZERO: res_q.acc <= 64'd0;
            DIV_RUN: begin
                if (!diff[32]) begin
                    rem_q <= diff[31:0];
                    quo_q <= {quo_q[30:0], 1'b1};
                end else begin
                    rem_q <= trial[31:0];
                    quo_q <= {quo_q[30:0], 1'b0};
                end
            end
            DIV_DONE: begin
                if (req_i.start && !ready_q) begin
                    res_q.half.hi <= neg_rem_q ? (~rem_q + 32'd1) : rem_q;
                    res_q.half.lo <= neg_quo_q ? (~quo_q + 32'd1) : quo_q;
                end
            end
            default: begin
            end
        endcase
    end

    assign rsp_o.ready    = ready_q;
    assign rsp_o.quot_rem = res_q;

endmodule

// File: hdl/ex_commit.sv
`timescale 1ns/100ps

module ex_commit
    import exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  result_t result_i,
    input  logic    capture_i,
    output result_t res_o,
    output logic    res_valid_o,
    output logic    fwd_whilo_o,
    output hilo_u   fwd_hilo_o,
    output hilo_u   hilo_o
);
    result_t res_q;
    logic    valid_q;
    hilo_u   hilo_q;
    logic    hilo_we;

    always_ff @(posedge clk) begin
        if (capture_i) begin
            res_q <= result_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= capture_i;  // one cycle per accepted issue
        end
    end

    // the pending write sits in res_q for one cycle before landing here
    assign hilo_we = valid_q && res_q.whilo;

    always_ff @(posedge clk) begin
        if (rst) begin
            hilo_q <= '0;
        end else if (hilo_we) begin
            hilo_q <= res_q.hilo;
        end
    end

    assign res_o       = res_q;
    assign res_valid_o = valid_q;

    // forward source for the next instruction's hi/lo read
    assign fwd_whilo_o = hilo_we;
    assign fwd_hilo_o  = res_q.hilo;
    assign hilo_o      = hilo_q;

endmodule

// File: hdl/exec_top.sv
`timescale 1ns/100ps

module exec_top
    import exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  issue_t  issue_i,
    input  logic    issue_valid_i,
    output result_t res_o,
    output logic    res_valid_o,
    output logic    stall_o
);
    result_t  alu_res;
    div_req_t div_req;
    div_rsp_t div_rsp;
    logic     fwd_whilo;
    hilo_u    fwd_hilo;
    hilo_u    hilo;
    logic     capture;

    assign capture = issue_valid_i && !stall_o;  // accepted this cycle

    alu_core i_alu_core (
        .clk           (clk),
        .rst           (rst),
        .issue_i       (issue_i),
        .issue_valid_i (issue_valid_i),
        .fwd_whilo_i   (fwd_whilo),
        .fwd_hilo_i    (fwd_hilo),
        .hilo_i        (hilo),
        .div_rsp_i     (div_rsp),
        .div_req_o     (div_req),
        .result_o      (alu_res),
        .stall_o       (stall_o)
    );

    div_unit i_div_unit (
        .clk   (clk),
        .rst   (rst),
        .req_i (div_req),
        .rsp_o (div_rsp)
    );

    ex_commit i_ex_commit (
        .clk         (clk),
        .rst         (rst),
        .result_i    (alu_res),
        .capture_i   (capture),
        .res_o       (res_o),
        .res_valid_o (res_valid_o),
        .fwd_whilo_o (fwd_whilo),
        .fwd_hilo_o  (fwd_hilo),
        .hilo_o      (hilo)
    );

endmodule

// File: dv/exec_checker.sv
`timescale 1ns/100ps

module exec_checker (
    input logic clk,
    input logic rst,
    input logic stall_i,
    input logic res_valid_i
);
    int unsigned assert_fails = 0;

    stall_low_in_reset: assert property (@(posedge clk) rst |-> !stall_i)
        else begin
            assert_fails++;
            $error("stall high while in reset");
        end

    // two stalled cycles in a row mean nothing was captured in between
    no_valid_in_long_stall: assert property (@(posedge clk) disable iff (rst)
        (stall_i && $past(stall_i)) |-> !res_valid_i)
        else begin
            assert_fails++;
            $error("result valid during a long stall");
        end

    no_result_from_stall: assert property (@(posedge clk) disable iff (rst)
        $rose(res_valid_i) |-> !$past(stall_i))
        else begin
            assert_fails++;
            $error("result valid rose after a stalled cycle");
        end

endmodule

bind exec_top exec_checker i_exec_checker (
    .clk         (clk),
    .rst         (rst),
    .stall_i     (stall_o),
    .res_valid_i (res_valid_o)
);

// File: dv/exec_tb.sv
`timescale 1ns/100ps

module exec_tb
    import exec_pkg::*;
();
    localparam int    max_tests  = 64;
    localparam string trace_file = "dv/exec_trace.txt";

    logic    clk = 1'b0;
    logic    rst;
    issue_t  issue_i;
    logic    issue_valid_i;
    result_t res_o;
    logic    res_valid_o;
    logic    stall_o;

    string   test_name [max_tests];
    issue_t  test_pkt [max_tests];
    result_t test_exp [max_tests];
    int      exp_stall [max_tests];
    int      seen_stall [max_tests];  // stalled cycles seen by the driver
    int      num_tests;
    int      num_done;
    int      pass_cnt;
    int      fail_cnt;
    int      cycle_cnt;
    int      cycle_limit;
    int      assert_cnt;
    bit      test_bad;

    exec_top i_exec_top (
        .clk           (clk),
        .rst           (rst),
        .issue_i       (issue_i),
        .issue_valid_i (issue_valid_i),
        .res_o         (res_o),
        .res_valid_o   (res_valid_o),
        .stall_o       (stall_o)
    );

    always #5 clk = ~clk;

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [7:0]  op_v;
        logic [2:0]  sel_v;
        logic [31:0] r1, r2, wdata, hi, lo;
        logic [4:0]  wd;
        logic        wreg, ewreg, ewhilo, eov, etrap;
        int          stall;
        issue_t      pkt;
        result_t     exp;
        fd = $fopen(trace_file, "r");
        if (fd == 0) begin
            $display("cannot open trace file %s", trace_file);
            return;
        end
        while (!$feof(fd) && num_tests < max_tests) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin  // skip blanks and column notes
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                            name, op_v, sel_v, r1, r2, wd, wreg,
                            wdata, ewreg, ewhilo, hi, lo, eov, etrap, stall);
                if (n == 15) begin
                    pkt.op            = aluop_e'(op_v);
                    pkt.sel           = alusel_e'(sel_v);
                    pkt.reg1          = r1;
                    pkt.reg2          = r2;
                    pkt.wd            = wd;
                    pkt.wreg          = wreg;
                    exp.wd            = wd;
                    exp.wreg          = ewreg;
                    exp.wdata         = wdata;
                    exp.whilo         = ewhilo;
                    exp.hilo.half.hi  = hi;
                    exp.hilo.half.lo  = lo;
                    exp.ov            = eov;
                    exp.trap          = etrap;
                    test_name[num_tests] = name;
                    test_pkt[num_tests]  = pkt;
                    test_exp[num_tests]  = exp;
                    exp_stall[num_tests] = stall;
                    num_tests++;
                end else begin
                    $display("malformed trace line, %0d fields read: %s", n, line);
                    fail_cnt++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_result(input string name, input result_t exp, input result_t act);
        result_t e;
        result_t a;
        e = exp;
        a = act;
        e.hilo = '0;  // hi/lo has its own check
        a.hilo = '0;
        if (a !== e) begin
            $write("CHECK FAILED %s result: expected wd=%h wreg=%b wdata=%h ",
                   name, e.wd, e.wreg, e.wdata);
            $write("whilo=%b ov=%b trap=%b, actual wd=%h wreg=%b wdata=%h ",
                   e.whilo, e.ov, e.trap, a.wd, a.wreg, a.wdata);
            $display("whilo=%b ov=%b trap=%b", a.whilo, a.ov, a.trap);
            test_bad = 1'b1;
        end
    endtask

    task automatic check_hilo(input string name, input hilo_u exp, input hilo_u act);
        if (act.acc !== exp.acc) begin
            $display("CHECK FAILED %s hilo: expected %h_%h, actual %h_%h",
                     name, exp.half.hi, exp.half.lo, act.half.hi, act.half.lo);
            test_bad = 1'b1;
        end
    endtask

    task automatic check_stall(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("CHECK FAILED %s stall cycles: expected %0d, actual %0d",
                     name, exp, act);
            test_bad = 1'b1;
        end
    endtask

    // next packet goes out on the accepting edge
    task automatic run_tests();
        int k;
        int n;
        @(posedge clk);
        for (k = 0; k < num_tests; k++) begin
            issue_i       <= test_pkt[k];
            issue_valid_i <= 1'b1;
            n = 0;
            @(negedge clk);
            while (stall_o) begin
                n++;
                @(negedge clk);
            end
            seen_stall[k] = n;
            @(posedge clk);
        end
        issue_valid_i <= 1'b0;
        issue_i       <= '0;
    endtask

    always @(negedge clk) begin
        if (!rst && res_valid_o) begin
            if (num_done >= num_tests) begin
                $display("result seen with no test pending");
                fail_cnt++;
            end else begin
                test_bad = 1'b0;
                check_result(test_name[num_done], test_exp[num_done], res_o);
                check_hilo(test_name[num_done], test_exp[num_done].hilo, res_o.hilo);
                check_stall(test_name[num_done], exp_stall[num_done], seen_stall[num_done]);
                if (test_bad) begin
                    fail_cnt++;
                    $display("%-16s mismatch", test_name[num_done]);
                end else begin
                    pass_cnt++;
                    $display("%-16s ok", test_name[num_done]);
                end
                num_done++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d tests done",
                     cycle_cnt, num_done, num_tests);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst           = 1'b1;
        issue_i       = '0;
        issue_valid_i = 1'b0;
        num_tests     = 0;
        num_done      = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        cycle_cnt     = 0;
        cycle_limit   = 0;
        load_trace();
        if (num_tests == 0) begin
            $display("no tests read from %s", trace_file);
            $display("RESULT: FAIL");
            $finish;
        end else begin
            cycle_limit = 40 * num_tests + 20;
            repeat (4) @(posedge clk);
            rst <= 1'b0;
            run_tests();
            while (num_done < num_tests) begin
                @(negedge clk);
            end
            repeat (2) @(posedge clk);  // room for a stray result
            assert_cnt = i_exec_top.i_exec_checker.assert_fails;
            $display("tests passed %0d, failed %0d, assertion failures %0d",
                     pass_cnt, fail_cnt, assert_cnt);
            if (fail_cnt == 0 && assert_cnt == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

// File: dv/exec_trace.txt
# name op sel reg1 reg2 wd wreg, then expected: wdata wreg whilo hi lo ov trap stall
# all hex except name and stall, which is a decimal count of stalled cycles
or_mix         25 1 f0f00f0f 12345678 01 1 f2f45f7f 1 0 00000000 00000000 0 0 0
and_mix        24 1 f0f00f0f 12345678 02 1 10300608 1 0 00000000 00000000 0 0 0
nor_mix        27 1 f0f00f0f 12345678 03 1 0d0ba080 1 0 00000000 00000000 0 0 0
xor_mix        26 1 f0f00f0f 12345678 04 1 e2c45977 1 0 00000000 00000000 0 0 0
sll_count_mask 7c 2 00000024 8000000f 05 1 000000f0 1 0 00000000 00000000 0 0 0
srl_by_8       02 2 00000008 80001234 06 1 00800012 1 0 00000000 00000000 0 0 0
sra_neg        03 2 00000008 80001234 07 1 ff800012 1 0 00000000 00000000 0 0 0
sra_pos        03 2 00000004 7ffffff0 08 1 07ffffff 1 0 00000000 00000000 0 0 0
add_ov         20 4 70000000 20000000 09 1 90000000 0 0 00000000 00000000 1 0 0
addu_wrap      21 4 70000000 20000000 0a 1 90000000 1 0 00000000 00000000 0 0 0
add_neg        20 4 00000005 fffffffd 0b 1 00000002 1 0 00000000 00000000 0 0 0
sub_neg        22 4 00000003 00000005 0c 1 fffffffe 1 0 00000000 00000000 0 0 0
sub_ov         22 4 80000000 00000001 0d 1 7fffffff 0 0 00000000 00000000 1 0 0
subu_wrap      23 4 80000000 00000001 0e 1 7fffffff 1 0 00000000 00000000 0 0 0
slt_mixed      2a 4 ffffffff 00000001 0f 1 00000001 1 0 00000000 00000000 0 0 0
sltu_mixed     2b 4 ffffffff 00000001 10 1 00000000 1 0 00000000 00000000 0 0 0
sltu_rev       2b 4 00000001 ffffffff 11 1 00000001 1 0 00000000 00000000 0 0 0
teq_hit        34 0 00001234 00001234 00 0 00000000 0 0 00000000 00000000 0 1 0
teq_miss       34 0 00001234 00001235 00 0 00000000 0 0 00000000 00000000 0 0 0
tne_hit        36 0 00000001 00000002 00 0 00000000 0 0 00000000 00000000 0 1 0
tge_signed     30 0 ffffffff 00000001 00 0 00000000 0 0 00000000 00000000 0 0 0
tgeu_unsigned  31 0 ffffffff 00000001 00 0 00000000 0 0 00000000 00000000 0 1 0
tlt_signed     32 0 ffffffff 00000001 00 0 00000000 0 0 00000000 00000000 0 1 0
tltu_unsigned  33 0 ffffffff 00000001 00 0 00000000 0 0 00000000 00000000 0 0 0
mult_neg       18 0 fffffffe 00000003 00 0 00000000 0 1 ffffffff fffffffa 0 0 0
multu_big      19 0 fffffffe 00000003 00 0 00000000 0 1 00000002 fffffffa 0 0 0
mul_low        a9 5 00010003 00020005 12 1 000b000f 1 1 00000002 000b000f 0 0 0
madd_neg       a6 0 ffffffff 00000010 00 0 00000000 0 1 00000002 000affff 0 0 1
msub_small     aa 0 00000003 00000004 00 0 00000000 0 1 00000002 000afff3 0 0 1
maddu_big      a8 0 80000000 00000002 00 0 00000000 0 1 00000003 000afff3 0 0 1
mfhi_after     10 3 00000000 00000000 13 1 00000003 1 0 00000000 00000000 0 0 0
mflo_after     12 3 00000000 00000000 14 1 000afff3 1 0 00000000 00000000 0 0 0
div_neg_dvd    1a 0 fffffff9 00000002 00 0 00000000 0 1 ffffffff fffffffd 0 0 34
div_neg_dvs    1a 0 00000007 fffffffe 00 0 00000000 0 1 00000001 fffffffd 0 0 34
divu_big       1b 0 fffffff9 00000002 00 0 00000000 0 1 00000001 7ffffffc 0 0 34
div_by_zero    1a 0 00001234 00000000 00 0 00000000 0 1 00000000 00000000 0 0 2
divu_small     1b 0 00000064 00000007 00 0 00000000 0 1 00000002 0000000e 0 0 34
mthi_only      11 0 a5a5a5a5 00000000 00 0 00000000 0 1 a5a5a5a5 0000000e 0 0 0
mtlo_only      13 0 5a5a5a5a 00000000 00 0 00000000 0 1 a5a5a5a5 5a5a5a5a 0 0 0
mfhi_b2b       10 3 00000000 00000000 15 1 a5a5a5a5 1 0 00000000 00000000 0 0 0
mflo_b2b       12 3 00000000 00000000 16 1 5a5a5a5a 1 0 00000000 00000000 0 0 0

// File: project.f
hdl/exec_pkg.sv
hdl/alu_core.sv
hdl/div_unit.sv
hdl/ex_commit.sv
hdl/exec_top.sv
dv/exec_checker.sv
dv/exec_tb.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - hdl/exec_pkg.sv
  - hdl/alu_core.sv
  - hdl/div_unit.sv
  - hdl/ex_commit.sv
  - hdl/exec_top.sv
  - target: dv
    files:
      - dv/exec_checker.sv
      - dv/exec_tb.sv
